// ==== fft_pkg.sv ====
package fft_pkg;

    // frame geometry
    localparam int FFT_N      = 16;
    localparam int FFT_STAGES = 4;

    // word widths
    localparam int DATA_W  = 16;
    localparam int COEF_W  = 32;
    localparam int TW_FRAC = 16;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0] coef_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // one complete frame, index n holds point n
    typedef cplx_t [FFT_N-1:0] frame_t;

    // one output beat, either all real or all imaginary parts
    typedef sample_t [FFT_N-1:0] bins_t;

    typedef struct packed {
        coef_t re;
        coef_t im;
    } twiddle_t;

    // W^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), Q16
    localparam twiddle_t TWIDDLE [0:FFT_N/2-1] = '{
        '{re: 32'sh0001_0000, im: 32'sh0000_0000},
        '{re: 32'sh0000_ec83, im: 32'shffff_9e09},
        '{re: 32'sh0000_b504, im: 32'shffff_4afc},
        '{re: 32'sh0000_61f7, im: 32'shffff_137d},
        '{re: 32'sh0000_0000, im: 32'shffff_0000},
        '{re: 32'shffff_9e09, im: 32'shffff_137d},
        '{re: 32'shffff_4afc, im: 32'shffff_4afc},
        '{re: 32'shffff_137d, im: 32'shffff_9e09}
    };

    // DIF leaves the bins in bit-reversed order
    function automatic logic [FFT_STAGES-1:0] bit_reverse(
        input logic [FFT_STAGES-1:0] idx
    );
        logic [FFT_STAGES-1:0] rev;
        for (int i = 0; i < FFT_STAGES; i++) begin
            rev[i] = idx[FFT_STAGES-1-i];
        end
        return rev;
    endfunction

endpackage

// ==== sample_loader.sv ====
`timescale 1ns/1ps

module sample_loader
    import fft_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output frame_t  frame,
    output logic    frame_valid
);

    localparam int CNT_W = $clog2(FFT_N);

    logic [CNT_W-1:0] cnt;
    logic             last;

    // working buffer, refilled while the shadow copy is transformed
    bins_t work;
    bins_t work_next;

    assign last = (cnt == CNT_W'(FFT_N - 1));

    // buffer contents including the sample on this edge
    always_comb begin
        work_next = work;
        if (fir_valid) begin
            work_next[cnt] = fir_d;
        end
    end

    // sample counter, wraps at the frame boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (fir_valid) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= fir_valid && last;
        end
    end

    always_ff @(posedge clk) begin
        if (fir_valid) begin
            work <= work_next;
        end
    end

    // shadow copy, real input only
    always_ff @(posedge clk) begin
        if (fir_valid && last) begin
            for (int n = 0; n < FFT_N; n++) begin
                frame[n].re <= work_next[n];
                frame[n].im <= '0;
            end
        end
    end

endmodule

// ==== radix2_butterfly.sv ====
`timescale 1ns/1ps

module radix2_butterfly
    import fft_pkg::*;
(
    input  cplx_t    a,
    input  cplx_t    b,
    input  twiddle_t w,
    output cplx_t    top,
    output cplx_t    bottom
);

    // full width for the twiddle products
    localparam int PROD_W = DATA_W + COEF_W;

    logic signed [DATA_W:0]   sum_re;
    logic signed [DATA_W:0]   sum_im;
    logic signed [PROD_W-1:0] dr;
    logic signed [PROD_W-1:0] di;
    logic signed [PROD_W-1:0] wr;
    logic signed [PROD_W-1:0] wi;
    logic signed [PROD_W-1:0] prod_re;
    logic signed [PROD_W-1:0] prod_im;

    // upper output, no twiddle
    assign sum_re = a.re + b.re;
    assign sum_im = a.im + b.im;

    assign top.re = sum_re[DATA_W-1:0];
    assign top.im = sum_im[DATA_W-1:0];

    // difference, sign extended
    assign dr = a.re - b.re;
    assign di = a.im - b.im;

    assign wr = w.re;
    assign wi = w.im;

    // complex multiply by W
    assign prod_re = dr * wr - di * wi;
    assign prod_im = dr * wi + di * wr;

    // back from Q16 then keep the low data bits
    assign bottom.re = sample_t'(prod_re >>> TW_FRAC);
    assign bottom.im = sample_t'(prod_im >>> TW_FRAC);

endmodule

// ==== fft_stage.sv ====
`timescale 1ns/1ps

module fft_stage
    import fft_pkg::*;
#(
    parameter int STAGE = 0
) (
    input  frame_t din,
    output frame_t dout
);

    localparam int NUM_BF = FFT_N / 2;

    // distance between the two points of a pair
    localparam int SPAN = NUM_BF >> STAGE;

    // twiddle step for this stage
    localparam int TW_STEP = 1 << STAGE;

    cplx_t top_w [NUM_BF];
    cplx_t bot_w [NUM_BF];

    // upper index of butterfly g, the one whose SPAN bit is clear
    function automatic int upper_index(input int g);
        return (g / SPAN) * (2 * SPAN) + (g % SPAN);
    endfunction

    for (genvar g = 0; g < NUM_BF; g++) begin : g_bf
        localparam int J  = upper_index(g);
        localparam int TW = (J % SPAN) * TW_STEP;

        radix2_butterfly u_bf (
            .a      (din[J]),
            .b      (din[J + SPAN]),
            .w      (TWIDDLE[TW]),
            .top    (top_w[g]),
            .bottom (bot_w[g])
        );
    end

    // results go back to the positions they came from
    always_comb begin
        dout = din;
        for (int g = 0; g < NUM_BF; g++) begin
            dout[upper_index(g)]        = top_w[g];
            dout[upper_index(g) + SPAN] = bot_w[g];
        end
    end

endmodule

// ==== result_unload.sv ====
`timescale 1ns/1ps

module result_unload
    import fft_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   frame_valid,
    input  frame_t spectrum,
    output bins_t  fft_d,
    output logic   fft_valid
);

    bins_t re_order;
    bins_t im_order;
    bins_t im_hold;

    // high while the imaginary beat is due
    logic beat;

    // undo the bit-reversed order of the last stage
    always_comb begin
        for (int n = 0; n < FFT_N; n++) begin
            re_order[n] = spectrum[bit_reverse(FFT_STAGES'(n))].re;
            im_order[n] = spectrum[bit_reverse(FFT_STAGES'(n))].im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat      <= 1'b0;
            fft_valid <= 1'b0;
        end else begin
            beat      <= frame_valid;
            fft_valid <= frame_valid || beat;
        end
    end

    // real beat first, imaginary beat on the next edge
    always_ff @(posedge clk) begin
        if (rst) begin
            fft_d <= '0;
        end else if (frame_valid) begin
            fft_d <= re_order;
        end else if (beat) begin
            fft_d <= im_hold;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid) begin
            im_hold <= im_order;
        end
    end

endmodule

// ==== fft16_top.sv ====
`timescale 1ns/1ps

module fft16_top
    import fft_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output bins_t   fft_d,
    output logic    fft_valid
);

    logic   frame_valid;

    // stage_data[s] feeds stage s, the last entry is the spectrum
    frame_t stage_data [0:FFT_STAGES];

    sample_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .frame       (stage_data[0]),
        .frame_valid (frame_valid)
    );

    // four combinational DIF stages
    for (genvar s = 0; s < FFT_STAGES; s++) begin : g_stage
        fft_stage #(
            .STAGE (s)
        ) u_stage (
            .din  (stage_data[s]),
            .dout (stage_data[s + 1])
        );
    end

    result_unload u_unload (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .spectrum    (stage_data[FFT_STAGES]),
        .fft_d       (fft_d),
        .fft_valid   (fft_valid)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset held for the first four edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== fft16_props.sv ====
`timescale 1ns/1ps

module fft16_props (
    input logic clk,
    input logic rst,
    input logic frame_valid,
    input logic fft_valid
);

    // bumped by every failing assertion
    int fail_count = 0;

    // frame strobe is a single-cycle pulse
    a_frame_pulse: assert property (@(posedge clk) disable iff (rst)
        frame_valid |=> !frame_valid)
    else begin
        fail_count++;
        $error("frame_valid high on two consecutive cycles");
    end

    // real beat then imaginary beat, then low again
    a_two_beats: assert property (@(posedge clk) disable iff (rst)
        $rose(fft_valid) |=> fft_valid ##1 !fft_valid)
    else begin
        fail_count++;
        $error("fft_valid run is not exactly two cycles long");
    end

    a_frame_to_out: assert property (@(posedge clk) disable iff (rst)
        frame_valid |=> $rose(fft_valid))
    else begin
        fail_count++;
        $error("fft_valid did not rise one cycle after frame_valid");
    end

    a_out_from_frame: assert property (@(posedge clk) disable iff (rst)
        $rose(fft_valid) |-> $past(frame_valid))
    else begin
        fail_count++;
        $error("fft_valid rose without frame_valid on the cycle before");
    end

endmodule

bind fft16_top fft16_props u_props (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .fft_valid   (fft_valid)
);

// ==== fft16_tb.sv ====
`timescale 1ns/1ps

module fft16_tb
    import fft_pkg::*;
();

    localparam int N_BURST        = 8;
    localparam int N_GAPPED       = 4;
    localparam int TOTAL_SAMPLES  = FFT_N * (3 + N_BURST + N_GAPPED);
    localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 2 + 100;

    logic    clk;
    logic    rst;
    sample_t fir_d;
    logic    fir_valid;
    bins_t   fft_d;
    logic    fft_valid;

    // expected beats, frame names and real-beat arrival cycles
    bins_t exp_q [$];
    string name_q [$];
    int    rise_q [$];

    int          cycles = 0;
    logic        imag_next = 1'b0;
    string       cur_name;
    logic [31:0] lfsr_state;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    fft16_top uut (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_d     (fft_d),
        .fft_valid (fft_valid)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(
        input string                     name,
        input logic [$bits(bins_t)-1:0] expected,
        input logic [$bits(bins_t)-1:0] actual
    );
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // 12 bits sign extended so a full-frame sum stays in range
    function automatic sample_t random_sample();
        logic [11:0] r;
        r = take_bits(12);
        return {{4{r[11]}}, r};
    endfunction

    function automatic bins_t random_frame();
        bins_t x;
        for (int n = 0; n < FFT_N; n++) begin
            x[n] = random_sample();
        end
        return x;
    endfunction

    // in-place DIF with Q16 twiddles and bins returned in natural order
    function automatic void ref_fft(input bins_t x, output bins_t re_b, output bins_t im_b);
        cplx_t  pt [FFT_N];
        cplx_t  u;
        cplx_t  v;
        int     h;
        int     k;
        longint dr;
        longint di;
        longint wr;
        longint wi;
        for (int n = 0; n < FFT_N; n++) begin
            pt[n].re = x[n];
            pt[n].im = '0;
        end
        for (int s = 0; s < FFT_STAGES; s++) begin
            h = (FFT_N / 2) >> s;
            for (int j = 0; j < FFT_N; j++) begin
                if ((j & h) == 0) begin
                    u  = pt[j];
                    v  = pt[j + h];
                    k  = (j % h) << s;
                    wr = TWIDDLE[k].re;
                    wi = TWIDDLE[k].im;
                    dr = longint'(u.re) - longint'(v.re);
                    di = longint'(u.im) - longint'(v.im);
                    // sums wrap to 16 bits
                    pt[j].re     = u.re + v.re;
                    pt[j].im     = u.im + v.im;
                    pt[j + h].re = sample_t'((dr * wr - di * wi) >>> TW_FRAC);
                    pt[j + h].im = sample_t'((dr * wi + di * wr) >>> TW_FRAC);
                end
            end
        end
        for (int n = 0; n < FFT_N; n++) begin
            re_b[n] = pt[bit_reverse(FFT_STAGES'(n))].re;
            im_b[n] = pt[bit_reverse(FFT_STAGES'(n))].im;
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            fir_valid <= 1'b0;
        end
    endtask

    task automatic send_frame(input string name, input bins_t x, input logic gaps);
        bins_t re_b;
        bins_t im_b;
        for (int i = 0; i < FFT_N; i++) begin
            // at most one idle cycle ahead of each sample
            if (gaps && take_bits(1) == 32'd1) begin
                @(posedge clk);
                fir_valid <= 1'b0;
            end
            @(posedge clk);
            fir_valid <= 1'b1;
            fir_d     <= x[i];
        end
        ref_fft(x, re_b, im_b);
        exp_q.push_back(re_b);
        exp_q.push_back(im_b);
        name_q.push_back(name);
        // cycles still lags this edge by one
        // the last sample is taken on the next edge and the real beat one edge later
        rise_q.push_back(cycles + 3);
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, run still going after %0d cycles", cycles));
        end
    end

    // outputs are read on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            imag_next = 1'b0;
        end else if (fft_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("output beat seen while no frame was pending");
            end else if (!imag_next) begin
                cur_name = name_q[0];
                check_value({cur_name, "_latency"}, rise_q.pop_front(), cycles);
                check_value({cur_name, "_real"}, exp_q.pop_front(), fft_d);
                imag_next = 1'b1;
            end else begin
                check_value({cur_name, "_imag"}, exp_q.pop_front(), fft_d);
                void'(name_q.pop_front());
                imag_next = 1'b0;
            end
        end else if (imag_next) begin
            fail_run({"imaginary beat missing after the real beat of ", cur_name});
        end
    end

    initial begin
        bins_t x;
        bins_t e;
        bins_t re_b;
        bins_t im_b;
        fir_d      = '0;
        fir_valid  = 1'b0;
        lfsr_state = 32'hd0fe_d112;

        // quiet outputs after reset
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        check_value("reset_valid", '0, fft_valid);
        check_value("reset_data", '0, fft_d);
        idle_cycles(2);

        // impulse gives a flat spectrum
        x    = '0;
        x[0] = 16'sd1000;
        ref_fft(x, re_b, im_b);
        check_value("impulse_model_real", {FFT_N{16'sd1000}}, re_b);
        check_value("impulse_model_imag", '0, im_b);
        send_frame("impulse", x, 1'b0);
        idle_cycles(4);

        // constant lands in bin 0
        x    = {FFT_N{16'sd100}};
        e    = '0;
        e[0] = 16'sd1600;
        ref_fft(x, re_b, im_b);
        check_value("constant_model_real", e, re_b);
        check_value("constant_model_imag", '0, im_b);
        send_frame("constant", x, 1'b0);
        idle_cycles(4);

        // alternating sign lands in bin 8
        for (int n = 0; n < FFT_N; n++) begin
            x[n] = n[0] ? -16'sd100 : 16'sd100;
        end
        e    = '0;
        e[8] = 16'sd1600;
        ref_fft(x, re_b, im_b);
        check_value("alternating_model_real", e, re_b);
        check_value("alternating_model_imag", '0, im_b);
        send_frame("alternating", x, 1'b0);
        idle_cycles(4);

        // back to back with fir_valid never dropping
        for (int f = 0; f < N_BURST; f++) begin
            send_frame($sformatf("burst%0d", f), random_frame(), 1'b0);
        end
        idle_cycles(4);

        for (int f = 0; f < N_GAPPED; f++) begin
            send_frame($sformatf("gapped%0d", f), random_frame(), 1'b1);
        end
        idle_cycles(8);

        if (exp_q.size() != 0 || rise_q.size() != 0) begin
            fail_run($sformatf("%0d output beats never appeared", exp_q.size()));
        end else if (uut.u_props.fail_count != 0) begin
            fail_run($sformatf("%0d assertion failures in the bound checker",
                               uut.u_props.fail_count));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
fft_pkg.sv
sample_loader.sv
radix2_butterfly.sv
fft_stage.sv
result_unload.sv
fft16_top.sv
tb_clock_gen.sv
fft16_props.sv
fft16_tb.sv
